/* design/apu_reg_pkg.sv */
`default_nettype none

package apu_reg_pkg;

    // one square channel, duty in the top bits
    typedef struct packed {
        logic [1:0]  duty;
        logic [3:0]  env_init;
        logic        env_up;
        // ticks per envelope step, 0 freezes the volume
        logic [2:0]  env_period;
        logic [10:0] freq;
        logic        trigger;
    } square_regs_t;

    // vol_code 0 mute, 1 full, 2 half, 3 quarter
    typedef struct packed {
        logic        enable;
        logic [1:0]  vol_code;
        logic [10:0] freq;
    } wave_regs_t;

    // 32 nibbles, first sample in the top nibble
    localparam int unsigned WAVE_RAM_BITS = 128;

endpackage

`default_nettype wire

/* design/apu_audio_pkg.sv */
`default_nettype none

package apu_audio_pkg;

    typedef logic [3:0]  level_t;
    typedef logic [23:0] sample_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_sample_t;

    // clock dividers at 100 MHz
    localparam int unsigned CPU_DIV    = 24;
    localparam int unsigned SAMPLE_DIV = 2083;
    localparam int unsigned ENV_DIV    = 1562500;
    localparam int unsigned BCLK_HALF  = 16;

    // placement of levels and sawtooth in the codec word
    localparam int unsigned LEVEL_SHIFT = 20;
    localparam int unsigned SAW_SHIFT   = 18;

endpackage

`default_nettype wire

/* design/apu_timebase.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_timebase (
    input  logic clk_100,
    input  logic rst_n,
    output logic cpu_en,
    output logic env_tick,
    output logic new_sample
);
    import apu_audio_pkg::*;

    localparam int unsigned DIVS [3] = '{CPU_DIV, ENV_DIV, SAMPLE_DIV};

    logic [2:0] en;

    for (genvar i = 0; i < 3; i++) begin : g_div
        logic [$clog2(DIVS[i])-1:0] cnt;

        always_ff @(posedge clk_100 or negedge rst_n) begin
            if (!rst_n) begin
                cnt <= '0;
            end else if (cnt == DIVS[i] - 1) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end

        // pulse on the last count of each period
        assign en[i] = (cnt == DIVS[i] - 1);

        a_single_pulse: assert property (@(posedge clk_100) disable iff (!rst_n)
            en[i] |=> !en[i])
            else $error("timebase enable %0d high on two cycles in a row", i);
    end

    assign cpu_en     = en[0];
    assign env_tick   = en[1];
    assign new_sample = en[2];

endmodule

`default_nettype wire

/* design/square_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module square_channel (
    input  logic                      clk_100,
    input  logic                      rst_n,
    input  logic                      cpu_en,
    input  logic                      env_tick,
    input  apu_reg_pkg::square_regs_t regs,
    output apu_audio_pkg::level_t     level
);
    import apu_audio_pkg::*;

    logic [13:0] period;
    logic [13:0] timer;
    logic [2:0]  pos;
    logic [7:0]  pattern;
    logic [2:0]  env_cnt;
    level_t      volume;
    logic        trig_q;
    logic        trig_rise;

    // (2048 - freq) * 4 steps of cpu_en
    assign period    = {12'd2048 - {1'b0, regs.freq}, 2'b00};
    assign trig_rise = regs.trigger & ~trig_q;

    always_comb begin
        unique case (regs.duty)
            2'd0: pattern = 8'b0000_0001;
            2'd1: pattern = 8'b1000_0001;
            2'd2: pattern = 8'b1000_0111;
            2'd3: pattern = 8'b0111_1110;
        endcase
    end

    // phase timer and duty position, level updates on cpu_en only
    always_ff @(posedge clk_100 or negedge rst_n) begin
        if (!rst_n) begin
            timer <= '0;
            pos   <= '0;
            level <= '0;
        end else if (trig_rise) begin
            timer <= period;
            pos   <= '0;
        end else if (cpu_en) begin
            if (timer <= 14'd1) begin
                timer <= period;
                pos   <= pos + 3'd1;
            end else begin
                timer <= timer - 14'd1;
            end
            level <= pattern[pos] ? volume : '0;
        end
    end

    // volume envelope, saturating at both ends
    always_ff @(posedge clk_100 or negedge rst_n) begin
        if (!rst_n) begin
            trig_q  <= 1'b0;
            env_cnt <= '0;
            volume  <= '0;
        end else begin
            trig_q <= regs.trigger;
            if (trig_rise) begin
                volume  <= regs.env_init;
                env_cnt <= '0;
            end else if (env_tick && regs.env_period != 3'd0) begin
                if (env_cnt >= regs.env_period - 3'd1) begin
                    env_cnt <= '0;
                    if (regs.env_up && volume != 4'hf) begin
                        volume <= volume + 4'd1;
                    end else if (!regs.env_up && volume != 4'h0) begin
                        volume <= volume - 4'd1;
                    end
                end else begin
                    env_cnt <= env_cnt + 3'd1;
                end
            end
        end
    end

    a_env_frozen: assert property (@(posedge clk_100) disable iff (!rst_n)
        (regs.env_period == 3'd0 && !trig_rise) |=> $stable(volume))
        else $error("envelope volume moved while env_period is zero");

endmodule

`default_nettype wire

/* design/wave_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module wave_channel (
    input  logic                                    clk_100,
    input  logic                                    rst_n,
    input  logic                                    cpu_en,
    input  apu_reg_pkg::wave_regs_t                 regs,
    input  logic [apu_reg_pkg::WAVE_RAM_BITS-1:0]   wave_ram,
    output apu_audio_pkg::level_t                   level
);
    import apu_audio_pkg::*;

    logic [12:0] period;
    logic [12:0] timer;
    logic [4:0]  pos;
    level_t      nibble;

    // (2048 - freq) * 2 steps of cpu_en
    assign period = {12'd2048 - {1'b0, regs.freq}, 1'b0};

    // position 0 reads the top nibble
    assign nibble = wave_ram[$bits(wave_ram) - 1 - 4 * pos -: 4];

    always_ff @(posedge clk_100 or negedge rst_n) begin
        if (!rst_n) begin
            timer <= '0;
            pos   <= '0;
            level <= '0;
        end else if (cpu_en) begin
            if (!regs.enable) begin
                // disabled channel restarts from the first sample
                timer <= period;
                pos   <= '0;
                level <= '0;
            end else begin
                if (timer <= 13'd1) begin
                    timer <= period;
                    pos   <= pos + 5'd1;
                end else begin
                    timer <= timer - 13'd1;
                end
                unique case (regs.vol_code)
                    2'd0: level <= '0;
                    2'd1: level <= nibble;
                    2'd2: level <= nibble >> 1;
                    2'd3: level <= nibble >> 2;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* design/output_select.sv */
`timescale 1ns/1ps
`default_nettype none

module output_select (
    input  logic                          clk_100,
    input  logic                          rst_n,
    input  logic                          new_sample,
    input  logic [1:0]                    sel,
    input  apu_audio_pkg::level_t         square_level,
    input  apu_audio_pkg::level_t         wave_level,
    output apu_audio_pkg::stereo_sample_t sample,
    output logic                          sample_valid
);
    import apu_audio_pkg::*;

    logic [$bits(sample_t)-SAW_SHIFT-1:0] saw;
    sample_t word;
    logic    saw_sel;

    // channel levels sit in the top nibble, anything else plays the sawtooth
    always_comb begin
        saw_sel = 1'b0;
        unique case (sel)
            2'b01: word = sample_t'(square_level) << LEVEL_SHIFT;
            2'b10: word = sample_t'(wave_level) << LEVEL_SHIFT;
            default: begin
                word    = sample_t'(saw) << SAW_SHIFT;
                saw_sel = 1'b1;
            end
        endcase
    end

    // saw only advances on strobes where it is played
    always_ff @(posedge clk_100 or negedge rst_n) begin
        if (!rst_n) begin
            saw          <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= new_sample;
            if (new_sample && saw_sel) begin
                saw <= saw + 1'b1;
            end
        end
    end

    // held until the next strobe, both sides identical
    always_ff @(posedge clk_100) begin
        if (new_sample) begin
            sample.left  <= word;
            sample.right <= word;
        end
    end

endmodule

`default_nettype wire

/* design/i2s_transmitter.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_transmitter (
    input  logic                          clk_100,
    input  logic                          rst_n,
    input  logic                          sample_valid,
    input  apu_audio_pkg::stereo_sample_t sample,
    output logic                          bclk,
    output logic                          lrclk,
    output logic                          sdata
);
    import apu_audio_pkg::*;

    logic                         active;
    logic [$clog2(BCLK_HALF)-1:0] half_cnt;
    logic [5:0]                   bit_idx;
    logic [5:0]                   bit_next;
    logic [63:0]                  shreg;
    logic [63:0]                  frame;
    logic                         half_done;
    logic                         fall;

    // per half: one zero bit, 24 data bits msb first, zero pad
    assign frame     = {1'b0, sample.left, 7'd0, 1'b0, sample.right, 7'd0};
    assign half_done = active && (half_cnt == BCLK_HALF - 1);
    assign fall      = half_done && bclk;
    assign bit_next  = bit_idx + 6'd1;

    always_ff @(posedge clk_100 or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            half_cnt <= '0;
            bit_idx  <= '0;
            bclk     <= 1'b0;
            lrclk    <= 1'b0;
            sdata    <= 1'b0;
        end else if (sample_valid) begin
            active   <= 1'b1;
            half_cnt <= '0;
            bit_idx  <= '0;
            bclk     <= 1'b0;
            lrclk    <= 1'b0;
            sdata    <= frame[63];
        end else if (active) begin
            if (half_done) begin
                half_cnt <= '0;
                bclk     <= ~bclk;
                // data and word select move on the falling edge
                if (fall) begin
                    if (bit_idx == 6'd63) begin
                        active <= 1'b0;
                        lrclk  <= 1'b0;
                        sdata  <= 1'b0;
                    end else begin
                        bit_idx <= bit_next;
                        lrclk   <= bit_next[5];
                        sdata   <= shreg[62];
                    end
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100) begin
        if (sample_valid) begin
            shreg <= frame;
        end else if (fall) begin
            shreg <= shreg << 1;
        end
    end

    // frame must finish before the next sample strobe
    a_no_overrun: assert property (@(posedge clk_100) disable iff (!rst_n)
        sample_valid |-> !active)
        else $error("sample_valid arrived while an I2S frame was still active");

endmodule

`default_nettype wire

/* design/apu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_top (
    input  logic                                  clk_100,
    input  logic                                  rst_n,
    input  logic [1:0]                            sel,
    input  apu_reg_pkg::square_regs_t             square_regs,
    input  apu_reg_pkg::wave_regs_t               wave_regs,
    input  logic [apu_reg_pkg::WAVE_RAM_BITS-1:0] wave_ram,
    output logic                                  bclk,
    output logic                                  lrclk,
    output logic                                  sdata
);
    import apu_audio_pkg::*;

    logic           cpu_en;
    logic           env_tick;
    logic           new_sample;
    level_t         square_level;
    level_t         wave_level;
    stereo_sample_t sample;
    logic           sample_valid;

    apu_timebase timebase0 (
        .clk_100    (clk_100),
        .rst_n      (rst_n),
        .cpu_en     (cpu_en),
        .env_tick   (env_tick),
        .new_sample (new_sample)
    );

    square_channel square0 (
        .clk_100  (clk_100),
        .rst_n    (rst_n),
        .cpu_en   (cpu_en),
        .env_tick (env_tick),
        .regs     (square_regs),
        .level    (square_level)
    );

    wave_channel wave0 (
        .clk_100  (clk_100),
        .rst_n    (rst_n),
        .cpu_en   (cpu_en),
        .regs     (wave_regs),
        .wave_ram (wave_ram),
        .level    (wave_level)
    );

    // sample register between the channels and the serializer
    output_select select0 (
        .clk_100      (clk_100),
        .rst_n        (rst_n),
        .new_sample   (new_sample),
        .sel          (sel),
        .square_level (square_level),
        .wave_level   (wave_level),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    i2s_transmitter i2s0 (
        .clk_100      (clk_100),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample       (sample),
        .bclk         (bclk),
        .lrclk        (lrclk),
        .sdata        (sdata)
    );

endmodule

`default_nettype wire

/* testbench/apu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_tb;
    import apu_reg_pkg::*;
    import apu_audio_pkg::*;

    typedef enum logic [2:0] {SKIP, SAW, HOLD, SQUARE, ENV, WAVE} check_t;

    localparam int unsigned SAW_FRAMES    = 8;
    localparam int unsigned SQUARE_FRAMES = 64;
    localparam int unsigned HOLD_FRAMES   = 4;
    localparam int unsigned WAVE_FRAMES   = 4;
    // enough frames to span three envelope ticks
    localparam int unsigned ENV_FRAMES    = 3 * ENV_DIV / SAMPLE_DIV + 2;
    localparam int unsigned RUN_FRAMES    = SAW_FRAMES + SQUARE_FRAMES + HOLD_FRAMES
                                            + 5 * WAVE_FRAMES + 8;
    localparam int unsigned TIMEOUT_CYCLES = (RUN_FRAMES + 16) * SAMPLE_DIV + 3 * ENV_DIV;
    localparam sample_t     SAW_STEP      = 24'd1 << SAW_SHIFT;

    logic                     clk_100;
    logic                     rst_n;
    logic [1:0]               sel;
    square_regs_t             square_regs;
    wave_regs_t               wave_regs;
    logic [WAVE_RAM_BITS-1:0] wave_ram;
    logic                     bclk;
    logic                     lrclk;
    logic                     sdata;

    // frame decoder state
    logic [63:0] frame_bits  = '0;
    logic [5:0]  bit_cnt     = '0;
    sample_t     dec_left    = '0;
    sample_t     dec_right   = '0;
    sample_t     prev_left   = '0;
    sample_t     prev_right  = '0;
    int          frames_seen = 0;
    logic        seen_bclk   = 1'b0;
    logic        clk_seen    = 1'b0;
    event        frame_done;

    check_t      mode         = SAW;
    string       test_name    = "sawtooth";
    sample_t     hold_ref     = '0;
    sample_t     sq_high      = '0;
    sample_t     env_last     = '0;
    sample_t     wave_expect  = '0;
    logic        seen_zero    = 1'b0;
    logic        seen_high    = 1'b0;
    logic        env_dropped  = 1'b0;
    int          value_errors = 0;
    int          other_errors = 0;
    logic [31:0] lfsr         = 32'h85f8;

    apu_top dut0 (
        .clk_100     (clk_100),
        .rst_n       (rst_n),
        .sel         (sel),
        .square_regs (square_regs),
        .wave_regs   (wave_regs),
        .wave_ram    (wave_ram),
        .bclk        (bclk),
        .lrclk       (lrclk),
        .sdata       (sdata)
    );

    // 4 ns period
    initial begin
        clk_100 = 1'b0;
        forever #2 clk_100 = ~clk_100;
    end

    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic wait_frames(input int n);
        repeat (n) @(frame_done);
    endtask

    task automatic check_value(input string name, input sample_t expected,
                               input sample_t actual);
        assert (actual === expected)
        else begin
            value_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_frame();
        sample_t expected;
        check_value("left/right", dec_left, dec_right);
        case (mode)
            SAW: begin
                // first frame after reset carries a zero sawtooth
                expected = (frames_seen == 1) ? '0 : prev_left + SAW_STEP;
                check_value(test_name, expected, dec_left);
                expected = (frames_seen == 1) ? '0 : prev_right + SAW_STEP;
                check_value(test_name, expected, dec_right);
                check_value("sawtooth low bits", '0, dec_left & (SAW_STEP - 1));
            end
            HOLD: check_value(test_name, hold_ref + SAW_STEP, dec_left);
            SQUARE: begin
                assert (dec_left == '0 || dec_left == sq_high)
                else begin
                    value_errors++;
                    $display("[ERROR] %s: expected 0 or %h, actual %h",
                             test_name, sq_high, dec_left);
                end
                if (dec_left == '0) begin
                    seen_zero = 1'b1;
                end
                if (dec_left == sq_high) begin
                    seen_high = 1'b1;
                end
            end
            ENV: begin
                if (dec_left != '0) begin
                    assert (dec_left <= env_last)
                    else begin
                        value_errors++;
                        $display("[ERROR] %s: expected at most %h, actual %h",
                                 test_name, env_last, dec_left);
                    end
                    env_last = dec_left;
                    if (dec_left < ({20'd0, 4'hf} << LEVEL_SHIFT)) begin
                        env_dropped = 1'b1;
                    end
                end
            end
            WAVE: check_value(test_name, wave_expect, dec_left);
            default: ;
        endcase
    endtask

    // sdata is stable on rising bclk
    always @(posedge bclk) begin
        seen_bclk = 1'b1;
        assert (lrclk === bit_cnt[5])
        else begin
            value_errors++;
            $display("[ERROR] lrclk at bit %0d: expected %b, actual %b",
                     bit_cnt, bit_cnt[5], lrclk);
        end
        frame_bits = {frame_bits[62:0], sdata};
        if (bit_cnt == 6'd63) begin
            prev_left  = dec_left;
            prev_right = dec_right;
            // one zero bit leads each half
            dec_left   = frame_bits[62:39];
            dec_right  = frame_bits[30:7];
            frames_seen++;
            check_frame();
            -> frame_done;
        end
        bit_cnt = bit_cnt + 6'd1;
    end

    always @(posedge clk_100) begin
        clk_seen <= 1'b1;
    end

    a_reset_quiet: assert property (@(posedge clk_100)
        (clk_seen && (!rst_n || !seen_bclk)) |-> (!bclk && !lrclk && !sdata))
        else begin
            other_errors++;
            $display("reset state: bclk, lrclk or sdata was not low in reset or before the first frame");
        end

    initial begin : stimulus
        logic [31:0] r;
        logic [3:0]  vol;
        logic [3:0]  nib;
        logic [10:0] freq;
        logic [1:0]  code;
        int          frames;
        int          k;

        rst_n       = 1'b0;
        sel         = 2'b00;
        square_regs = '0;
        wave_regs   = '0;
        wave_ram    = '0;
        repeat (2) @(posedge clk_100);
        rst_n <= 1'b1;

        // sawtooth straight out of reset
        wait_frames(SAW_FRAMES);
        hold_ref = dec_left;

        // square with a frozen random volume
        vol = 4'd0;
        while (vol == 4'd0) begin
            draw_bits(4, r);
            vol = r[3:0];
        end
        draw_bits(3, r);
        freq = 11'd2040 + r[2:0];
        @(posedge clk_100);
        sel         <= 2'b01;
        square_regs <= '{duty: 2'd2, env_init: vol, env_up: 1'b0, env_period: 3'd0,
                         freq: freq, trigger: 1'b1};
        mode = SKIP;
        wait_frames(1);
        sq_high   = {20'd0, vol} << LEVEL_SHIFT;
        test_name = "square levels";
        mode      = SQUARE;
        wait_frames(SQUARE_FRAMES);
        assert (seen_zero && seen_high)
        else begin
            other_errors++;
            $display("square levels: output did not show both zero and the volume");
        end

        // sawtooth picks up where it stopped
        @(posedge clk_100);
        sel <= 2'b00;
        test_name = "sawtooth hold";
        mode      = HOLD;
        wait_frames(1);
        test_name = "sawtooth";
        mode      = SAW;
        wait_frames(HOLD_FRAMES);

        // decaying envelope from full volume
        draw_bits(3, r);
        @(posedge clk_100);
        sel         <= 2'b01;
        square_regs <= '{duty: 2'd2, env_init: 4'hf, env_up: 1'b0, env_period: 3'd1,
                         freq: 11'd2040 + r[2:0], trigger: 1'b0};
        mode = SKIP;
        @(posedge clk_100);
        square_regs.trigger <= 1'b1;
        wait_frames(1);
        env_last  = {20'd0, 4'hf} << LEVEL_SHIFT;
        test_name = "envelope";
        mode      = ENV;
        frames    = 0;
        while (!env_dropped && frames < ENV_FRAMES) begin
            wait_frames(1);
            frames++;
        end
        assert (env_dropped)
        else begin
            other_errors++;
            $display("envelope: volume did not fall within three envelope periods");
        end
        wait_frames(4);

        // one nibble across the whole table
        draw_bits(4, r);
        nib = r[3:0];
        draw_bits(11, r);
        freq = r[10:0];
        for (k = 1; k <= 4; k++) begin
            code = k[1:0];
            @(posedge clk_100);
            sel       <= 2'b10;
            wave_ram  <= {(WAVE_RAM_BITS / 4){nib}};
            wave_regs <= '{enable: 1'b1, vol_code: code, freq: freq};
            mode = SKIP;
            wait_frames(1);
            // code 0 mutes, 1..3 shift by 0..2
            wave_expect = (code == 2'd0) ? '0 : ({20'd0, nib >> (code - 2'd1)} << LEVEL_SHIFT);
            test_name   = $sformatf("wave vol_code %0d", code);
            mode        = WAVE;
            wait_frames(WAVE_FRAMES);
        end

        mode = SKIP;
        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk_100);
        $display("timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
design/apu_reg_pkg.sv
design/apu_audio_pkg.sv
design/apu_timebase.sv
design/square_channel.sv
design/wave_channel.sv
design/output_select.sv
design/i2s_transmitter.sv
design/apu_top.sv
testbench/apu_tb.sv

/* Bender.yml */
package:
  name: apu_sound

sources:
  - design/apu_reg_pkg.sv
  - design/apu_audio_pkg.sv
  - design/apu_timebase.sv
  - design/square_channel.sv
  - design/wave_channel.sv
  - design/output_select.sv
  - design/i2s_transmitter.sv
  - design/apu_top.sv
  - target: test
    files:
      - testbench/apu_tb.sv
